// File: common/emesh_if.sv
`timescale 1ns/1ps

// one emesh packet, access is a single-cycle strobe
interface emesh_if import esaxi_pkg::*; ();

   logic      access;    // packet valid this cycle
   datamode_t datamode;
   ctrlmode_t ctrlmode;
   addr_t     dstaddr;
   data_t     data;      // zero for read requests

   // packet producer side
   modport src (output access, datamode, ctrlmode, dstaddr, data);

   // issue stage side
   modport dst (input access, datamode, ctrlmode, dstaddr, data);

endinterface

// File: common/esaxi_pkg.sv
package esaxi_pkg;

   // ##############################
   // bus and packet field types
   // ##############################
   typedef logic [31:0] addr_t;      // axi / emesh address
   typedef logic [31:0] data_t;      // axi / emesh data word
   typedef logic [1:0]  datamode_t;  // 0 byte, 1 half, 2 word (axi size coding)
   typedef logic [3:0]  ctrlmode_t;
   typedef logic [1:0]  burst_t;     // axi burst type
   typedef logic [1:0]  resp_t;      // axi response
   typedef logic [7:0]  len_t;       // burst length minus one

   // ##############################
   // constants
   // ##############################
   // own link id, matched against dstaddr[31:20]
   localparam logic [11:0] ELINK_ID = 12'h810;

   localparam burst_t BURST_INCR = 2'b01;  // fixed and wrap step nothing

   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   localparam datamode_t SIZE_WORD = 2'b10;

   // address bits below a 32b word
   localparam int ADDR_LSB = 2;

endpackage

// File: common/rd_ctx_if.sv
`timescale 1ns/1ps

// read burst context shared by the three read blocks
interface rd_ctx_if import esaxi_pkg::*; ();

   logic      active;  // burst in progress
   addr_t     addr;    // address of the current beat
   datamode_t size;    // burst size, also the request datamode
   logic      last;    // current beat is the final one
   logic      beat;    // r handshake of an accepted beat

   modport decode  (output active, addr, size, last, input beat);
   modport request (input active, addr, size, last, beat);
   modport result  (input size, output beat);

endinterface

// File: design/emesh_issue.sv
`timescale 1ns/1ps

module emesh_issue import esaxi_pkg::*;
(
   input  logic      s_axi_aclk,
   input  logic      s_axi_aresetn,
   emesh_if.dst      in,
   output logic      access,
   output datamode_t datamode,
   output ctrlmode_t ctrlmode,
   output addr_t     dstaddr,
   output data_t     data
);

   logic access_q;  // registered strobe before the id filter

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         access_q <= 1'b0;
      else
         access_q <= in.access;  // one packet per cycle
   end

   // packet fields, loaded every cycle
   always_ff @(posedge s_axi_aclk)
   begin
      datamode <= in.datamode;
      ctrlmode <= in.ctrlmode;
      dstaddr  <= in.dstaddr;
      data     <= in.data;
   end

   // packets to our own link id never leave the bridge
   assign access = access_q & (dstaddr[31:20] != ELINK_ID);

endmodule

// File: design/esaxi.sv
`timescale 1ns/1ps

module esaxi import esaxi_pkg::*;
(
   input  logic      s_axi_aclk,
   input  logic      s_axi_aresetn,
   // write address channel
   input  addr_t     s_axi_awaddr,
   input  burst_t    s_axi_awburst,
   input  datamode_t s_axi_awsize,
   input  logic      s_axi_awvalid,
   output logic      s_axi_awready,
   // write data channel
   input  data_t     s_axi_wdata,
   input  logic [3:0] s_axi_wstrb,
   input  logic      s_axi_wlast,
   input  logic      s_axi_wvalid,
   output logic      s_axi_wready,
   // write response channel
   output resp_t     s_axi_bresp,
   output logic      s_axi_bvalid,
   input  logic      s_axi_bready,
   // read address channel
   input  addr_t     s_axi_araddr,
   input  burst_t    s_axi_arburst,
   input  datamode_t s_axi_arsize,
   input  len_t      s_axi_arlen,
   input  logic      s_axi_arvalid,
   output logic      s_axi_arready,
   // read data channel
   output data_t     s_axi_rdata,
   output resp_t     s_axi_rresp,
   output logic      s_axi_rlast,
   output logic      s_axi_rvalid,
   input  logic      s_axi_rready,
   // config
   input  ctrlmode_t ecfg_tx_ctrlmode,
   // write packets to tx fifo
   output logic      emwr_access,
   output datamode_t emwr_datamode,
   output ctrlmode_t emwr_ctrlmode,
   output addr_t     emwr_dstaddr,
   output data_t     emwr_data,
   input  logic      emwr_progfull,
   // read requests to tx fifo
   output logic      emrq_access,
   output datamode_t emrq_datamode,
   output ctrlmode_t emrq_ctrlmode,
   output addr_t     emrq_dstaddr,
   // read responses from rx fifo
   input  data_t     emrr_data,
   input  logic      emrr_access,
   input  logic      emrr_timeout,
   output logic      emrr_rd_en
);

   emesh_if  wr_pkt ();  // write decode -> write issue
   emesh_if  rq_pkt ();  // read request -> read issue
   rd_ctx_if rd_ctx ();  // read burst state

   // ##############################
   // write path
   // ##############################
   axi_write_channel write_channel_i (
      .s_axi_aclk       (s_axi_aclk),
      .s_axi_aresetn    (s_axi_aresetn),
      .s_axi_awaddr     (s_axi_awaddr),
      .s_axi_awburst    (s_axi_awburst),
      .s_axi_awsize     (s_axi_awsize),
      .s_axi_awvalid    (s_axi_awvalid),
      .s_axi_awready    (s_axi_awready),
      .s_axi_wdata      (s_axi_wdata),
      .s_axi_wstrb      (s_axi_wstrb),
      .s_axi_wlast      (s_axi_wlast),
      .s_axi_wvalid     (s_axi_wvalid),
      .s_axi_wready     (s_axi_wready),
      .s_axi_bresp      (s_axi_bresp),
      .s_axi_bvalid     (s_axi_bvalid),
      .s_axi_bready     (s_axi_bready),
      .emwr_progfull    (emwr_progfull),
      .ecfg_tx_ctrlmode (ecfg_tx_ctrlmode),
      .pkt              (wr_pkt.src)
   );

   emesh_issue write_issue_i (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .in            (wr_pkt.dst),
      .access        (emwr_access),
      .datamode      (emwr_datamode),
      .ctrlmode      (emwr_ctrlmode),
      .dstaddr       (emwr_dstaddr),
      .data          (emwr_data)
   );

   // ##############################
   // read path
   // ##############################
   axi_read_decode read_decode_i (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .s_axi_araddr  (s_axi_araddr),
      .s_axi_arburst (s_axi_arburst),
      .s_axi_arsize  (s_axi_arsize),
      .s_axi_arlen   (s_axi_arlen),
      .s_axi_arvalid (s_axi_arvalid),
      .s_axi_arready (s_axi_arready),
      .s_axi_rlast   (s_axi_rlast),
      .ctx           (rd_ctx.decode)
   );

   read_request read_request_i (
      .s_axi_aclk       (s_axi_aclk),
      .s_axi_aresetn    (s_axi_aresetn),
      .ecfg_tx_ctrlmode (ecfg_tx_ctrlmode),
      .ctx              (rd_ctx.request),
      .pkt              (rq_pkt.src)
   );

   emesh_issue read_issue_i (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .in            (rq_pkt.dst),
      .access        (emrq_access),
      .datamode      (emrq_datamode),
      .ctrlmode      (emrq_ctrlmode),
      .dstaddr       (emrq_dstaddr),
      .data          ()              // requests carry no data
   );

   read_result read_result_i (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .emrr_data     (emrr_data),
      .emrr_access   (emrr_access),
      .emrr_timeout  (emrr_timeout),
      .emrr_rd_en    (emrr_rd_en),
      .s_axi_rdata   (s_axi_rdata),
      .s_axi_rresp   (s_axi_rresp),
      .s_axi_rvalid  (s_axi_rvalid),
      .s_axi_rready  (s_axi_rready),
      .ctx           (rd_ctx.result)
   );

endmodule

// File: esaxi.f
common/esaxi_pkg.sv
common/emesh_if.sv
common/rd_ctx_if.sv
design/emesh_issue.sv
write/axi_write_channel.sv
read/axi_read_decode.sv
read/read_request.sv
read/read_result.sv
design/esaxi.sv
test/esaxi_assert.sv
test/esaxi_tb.sv

// File: read/axi_read_decode.sv
`timescale 1ns/1ps

module axi_read_decode import esaxi_pkg::*;
(
   input  logic      s_axi_aclk,
   input  logic      s_axi_aresetn,
   input  addr_t     s_axi_araddr,
   input  burst_t    s_axi_arburst,
   input  datamode_t s_axi_arsize,
   input  len_t      s_axi_arlen,
   input  logic      s_axi_arvalid,
   output logic      s_axi_arready,
   output logic      s_axi_rlast,
   rd_ctx_if.decode  ctx
);

   logic   ar_take;   // ar handshake
   logic   active_q;
   logic   last_q;
   addr_t  ar_addr;
   burst_t ar_burst;
   len_t   ar_len;    // beats left minus one

   assign ar_take = s_axi_arready & s_axi_arvalid;

   // arready and burst active
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_arready <= 1'b0;
         active_q      <= 1'b0;
         last_q        <= 1'b0;
      end
      else
      begin
         if (!s_axi_arready && !active_q)
            s_axi_arready <= 1'b1;
         else if (s_axi_arvalid)
            s_axi_arready <= 1'b0;
         if (ar_take)
            active_q <= 1'b1;
         else if (ctx.beat && last_q)
            active_q <= 1'b0;        // final beat accepted
         if (ar_take)
            last_q <= (s_axi_arlen == '0);  // single beat burst
         else if (ctx.beat && ar_len == len_t'(1))
            last_q <= 1'b1;
      end
   end

   // address, size and beat count
   always_ff @(posedge s_axi_aclk)
   begin
      if (ar_take)
      begin
         ar_addr  <= s_axi_araddr;
         ar_burst <= s_axi_arburst;
         ctx.size <= s_axi_arsize;
         ar_len   <= s_axi_arlen;
      end
      else if (ctx.beat)
      begin
         ar_len <= ar_len - 1'b1;
         if (ar_burst == BURST_INCR)  // fixed and wrap hold the address
            ar_addr <= {ar_addr[31:ADDR_LSB] + 1'b1, {ADDR_LSB{1'b0}}};
      end
   end

   assign ctx.active  = active_q;
   assign ctx.addr    = ar_addr;
   assign ctx.last    = last_q;
   assign s_axi_rlast = last_q;

endmodule

// File: read/read_request.sv
`timescale 1ns/1ps

module read_request import esaxi_pkg::*;
(
   input  logic      s_axi_aclk,
   input  logic      s_axi_aresetn,
   input  ctrlmode_t ecfg_tx_ctrlmode,
   rd_ctx_if.request ctx,
   emesh_if.src      pkt
);

   logic active_q;  // delayed active, for the leading edge
   logic next_q;    // non-last beat accepted

   // one request per beat, next one only after the previous answer
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         active_q   <= 1'b0;
         next_q     <= 1'b0;
         pkt.access <= 1'b0;
      end
      else
      begin
         active_q   <= ctx.active;
         next_q     <= ctx.beat & ~ctx.last;
         pkt.access <= (ctx.active & ~active_q) | next_q;  // first beat or next beat
      end
   end

   // request fields follow the current beat address
   always_ff @(posedge s_axi_aclk)
   begin
      pkt.datamode <= ctx.size;
      pkt.ctrlmode <= ecfg_tx_ctrlmode;
      pkt.dstaddr  <= ctx.addr;
   end

   assign pkt.data = '0;

endmodule

// File: read/read_result.sv
`timescale 1ns/1ps

module read_result import esaxi_pkg::*;
(
   input  logic     s_axi_aclk,
   input  logic     s_axi_aresetn,
   input  data_t    emrr_data,
   input  logic     emrr_access,
   input  logic     emrr_timeout,
   output logic     emrr_rd_en,
   output data_t    s_axi_rdata,
   output resp_t    s_axi_rresp,
   output logic     s_axi_rvalid,
   input  logic     s_axi_rready,
   rd_ctx_if.result ctx
);

   // single read in flight, so pop every response at once
   assign emrr_rd_en = emrr_access;

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         s_axi_rvalid <= 1'b0;
      else if (emrr_access)
         s_axi_rvalid <= 1'b1;
      else if (s_axi_rready)
         s_axi_rvalid <= 1'b0;  // held until taken
   end

   // narrow data copied to every lane
   always_ff @(posedge s_axi_aclk)
   begin
      if (emrr_access)
      begin
         case (ctx.size)
            2'b00:   s_axi_rdata <= {4{emrr_data[7:0]}};   // byte
            2'b01:   s_axi_rdata <= {2{emrr_data[15:0]}};  // half word
            default: s_axi_rdata <= emrr_data;
         endcase
         s_axi_rresp <= emrr_timeout ? RESP_SLVERR : RESP_OKAY;
      end
   end

   assign ctx.beat = s_axi_rvalid & s_axi_rready;  // accepted beat

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the esaxi testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f esaxi.f \
   --top-module esaxi_tb \
   -Mdir obj_dir -o esaxi_sim

# the simulator exits non-zero on a fatal error, the log decides
./obj_dir/esaxi_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
   echo "simulation FAILED"
   exit 1
fi
echo "simulation PASSED"

// File: test/esaxi_assert.sv
`timescale 1ns/1ps

module esaxi_assert import esaxi_pkg::*;
(
   input logic   s_axi_aclk,
   input logic   s_axi_aresetn,
   input addr_t  s_axi_awaddr,
   input burst_t s_axi_awburst,
   input logic   s_axi_awvalid,
   input logic   s_axi_awready,
   input logic   s_axi_wvalid,
   input logic   s_axi_wready,
   input logic   s_axi_bvalid,
   input logic   s_axi_bready,
   input logic   s_axi_rvalid,
   input logic   s_axi_rready,
   input data_t  s_axi_rdata,
   input logic   emwr_access,
   input logic   emrq_access,
   input logic   emrr_access
);

   logic   rd_pending;  // request out and not yet answered
   addr_t  wr_addr;     // address of the next write beat
   burst_t wr_burst;
   logic   own_beat;    // accepted beat aimed at our own link id

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         rd_pending <= 1'b0;
      else if (emrq_access)
         rd_pending <= 1'b1;
      else if (emrr_access)
         rd_pending <= 1'b0;  // answered
   end

   // beat address, one word further per incr beat
   always_ff @(posedge s_axi_aclk)
   begin
      if (s_axi_awvalid && s_axi_awready)
      begin
         wr_addr  <= s_axi_awaddr;
         wr_burst <= s_axi_awburst;
      end
      else if (s_axi_wvalid && s_axi_wready && wr_burst == BURST_INCR)
         wr_addr <= (wr_addr & ~addr_t'(3)) + addr_t'(4);
   end

   assign own_beat = s_axi_wvalid & s_axi_wready & (wr_addr[31:20] == ELINK_ID);

   // ##############################
   // protocol properties
   // ##############################
   bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
      else $error("bvalid dropped before bready");

   rvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
      else $error("rvalid or rdata changed before rready");

   // a packet leaves three edges after its beat
   own_id_filtered: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      emwr_access |-> !$past(own_beat, 3))
      else $error("write packet to own link id left the bridge");

   single_read: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
      emrq_access |-> !rd_pending)
      else $error("second read request while one is outstanding");

endmodule

// File: test/esaxi_tb.sv
`timescale 1ns/1ps

module esaxi_tb import esaxi_pkg::*;
();

   localparam int NUM_WR     = 40;
   localparam int NUM_RD     = 30;
   localparam int MAX_CYCLES = (NUM_WR + NUM_RD) * 200;  // watchdog limit

   logic s_axi_aclk, s_axi_aresetn;
   addr_t s_axi_awaddr, s_axi_araddr;
   burst_t s_axi_awburst, s_axi_arburst;
   datamode_t s_axi_awsize, s_axi_arsize;
   logic s_axi_awvalid, s_axi_awready, s_axi_wlast, s_axi_wvalid, s_axi_wready;
   data_t s_axi_wdata, s_axi_rdata, emwr_data, emrr_data;
   logic [3:0] s_axi_wstrb;
   resp_t s_axi_bresp, s_axi_rresp;
   logic s_axi_bvalid, s_axi_bready, s_axi_arvalid, s_axi_arready;
   len_t s_axi_arlen;
   logic s_axi_rlast, s_axi_rvalid, s_axi_rready;
   ctrlmode_t ecfg_tx_ctrlmode, emwr_ctrlmode, emrq_ctrlmode;
   logic emwr_access, emwr_progfull, emrq_access, emrr_access, emrr_timeout, emrr_rd_en;
   datamode_t emwr_datamode, emrq_datamode;
   addr_t emwr_dstaddr, emrq_dstaddr;

   integer seed = 13;
   int b_count = 0;             // b handshakes seen
   logic progfull_seen = 1'b0;  // prog-full as the last edge sampled it
   addr_t wr_addr_q[$];         // expected write packets
   data_t wr_data_q[$];
   datamode_t wr_mode_q[$];
   ctrlmode_t wr_ctrl_q[$];
   addr_t rq_addr_q[$];         // expected read request addresses
   datamode_t rq_mode;          // size of the running read burst
   ctrlmode_t rq_ctrl;
   data_t rr_data_q[$];         // expected r beats
   resp_t rr_resp_q[$];

   esaxi esaxi_i (.*);

   bind esaxi esaxi_assert esaxi_assert_i (
      .s_axi_aclk    (s_axi_aclk),
      .s_axi_aresetn (s_axi_aresetn),
      .s_axi_awaddr  (s_axi_awaddr),
      .s_axi_awburst (s_axi_awburst),
      .s_axi_awvalid (s_axi_awvalid),
      .s_axi_awready (s_axi_awready),
      .s_axi_wvalid  (s_axi_wvalid),
      .s_axi_wready  (s_axi_wready),
      .s_axi_bvalid  (s_axi_bvalid),
      .s_axi_bready  (s_axi_bready),
      .s_axi_rvalid  (s_axi_rvalid),
      .s_axi_rready  (s_axi_rready),
      .s_axi_rdata   (s_axi_rdata),
      .emwr_access   (emwr_access),
      .emrq_access   (emrq_access),
      .emrr_access   (emrr_access)
   );

   initial
   begin
      s_axi_aclk = 1'b0;
      forever #50 s_axi_aclk = ~s_axi_aclk;  // 100 ns period
   end

   // ##############################
   // checks
   // ##############################
   task automatic stop_run(string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic compare_addr(string name, addr_t got, addr_t exp);
      if (got !== exp)
         stop_run($sformatf("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got));
   endtask

   task automatic compare_data(string name, data_t got, data_t exp);
      if (got !== exp)
         stop_run($sformatf("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got));
   endtask

   task automatic compare_mode(string name, datamode_t got, datamode_t exp);
      if (got !== exp)
         stop_run($sformatf("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got));
   endtask

   task automatic compare_ctrl(string name, ctrlmode_t got, ctrlmode_t exp);
      if (got !== exp)
         stop_run($sformatf("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got));
   endtask

   task automatic compare_resp(string name, resp_t got, resp_t exp);
      if (got !== exp)
         stop_run($sformatf("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got));
   endtask

   task automatic compare_flag(string name, logic got, logic exp);
      if (got !== exp)
         stop_run($sformatf("[ERROR] %0t %s: expected %b, got %b", $time, name, exp, got));
   endtask

   // ##############################
   // write bursts
   // ##############################
   task automatic write_burst(input logic own_id);
      addr_t addr, beat_addr;
      burst_t burst;
      datamode_t size;
      ctrlmode_t ctrl;
      data_t d;
      logic [3:0] strb;
      logic [1:0] lane;
      int len, b_target;
      addr = $random(seed);
      if (own_id)
         addr[31:20] = ELINK_ID;
      else if (addr[31:20] == ELINK_ID)
         addr[31] = 1'b0;
      burst = ($random(seed) & 1) ? BURST_INCR : 2'b00;  // incr or fixed
      size = datamode_t'($unsigned($random(seed)) % 3);
      ctrl = ctrlmode_t'($random(seed));
      len = $unsigned($random(seed)) % 8;
      b_target = b_count + 1;
      @(posedge s_axi_aclk);
      ecfg_tx_ctrlmode <= ctrl;
      s_axi_awaddr <= addr;
      s_axi_awburst <= burst;
      s_axi_awsize <= size;
      s_axi_awvalid <= 1'b1;
      @(negedge s_axi_aclk);
      while (!s_axi_awready)
         @(negedge s_axi_aclk);
      @(posedge s_axi_aclk);
      s_axi_awvalid <= 1'b0;
      beat_addr = addr;
      for (int i = 0; i <= len; i++)
      begin
         d = $random(seed);
         strb = 4'($random(seed));
         if (strb == 4'b0000)
            strb = 4'b1000;  // always strobe something
         s_axi_wdata <= d;
         s_axi_wstrb <= strb;
         s_axi_wlast <= (i == len);
         s_axi_wvalid <= 1'b1;
         @(negedge s_axi_aclk);
         while (!s_axi_wready)
            @(negedge s_axi_aclk);
         // lowest strobed lane
         if (size == SIZE_WORD || strb[0])
            lane = 2'd0;  // words stay on lane 0
         else if (strb[1])
            lane = 2'd1;
         else if (strb[2])
            lane = 2'd2;
         else
            lane = 2'd3;
         if (beat_addr[31:20] != ELINK_ID)
         begin
            wr_addr_q.push_back({beat_addr[31:2], lane});
            wr_data_q.push_back(d >> (8 * lane));
            wr_mode_q.push_back(size);
            wr_ctrl_q.push_back(ctrl);
         end
         if (burst == BURST_INCR)
            beat_addr = {beat_addr[31:2] + 30'd1, 2'b00};
         @(posedge s_axi_aclk);  // handshake edge
      end
      s_axi_wvalid <= 1'b0;
      s_axi_wlast <= 1'b0;
      while (b_count < b_target)
         @(negedge s_axi_aclk);
   endtask

   // ##############################
   // read bursts
   // ##############################
   task automatic read_burst;
      addr_t addr, beat_addr;
      burst_t burst;
      int len;
      addr = $random(seed);
      addr[19] = 1'b0;  // bursts never leave the 1 MB region
      if (addr[31:20] == ELINK_ID)
         addr[31] = 1'b0;
      burst = ($random(seed) & 1) ? BURST_INCR : 2'b00;
      len = $unsigned($random(seed)) % 8;
      rq_mode = datamode_t'($unsigned($random(seed)) % 3);
      rq_ctrl = ctrlmode_t'($random(seed));
      beat_addr = addr;
      for (int i = 0; i <= len; i++)
      begin
         rq_addr_q.push_back(beat_addr);
         if (burst == BURST_INCR)
            beat_addr = {beat_addr[31:2] + 30'd1, 2'b00};  // step 4 to the next word
      end
      @(posedge s_axi_aclk);
      ecfg_tx_ctrlmode <= rq_ctrl;
      s_axi_araddr <= addr;
      s_axi_arburst <= burst;
      s_axi_arsize <= rq_mode;
      s_axi_arlen <= len_t'(len);
      s_axi_arvalid <= 1'b1;
      @(negedge s_axi_aclk);
      while (!s_axi_arready)
         @(negedge s_axi_aclk);
      @(posedge s_axi_aclk);
      s_axi_arvalid <= 1'b0;
      for (int i = 0; i <= len; i++)
      begin
         @(negedge s_axi_aclk);
         while (!(s_axi_rvalid && s_axi_rready))
            @(negedge s_axi_aclk);
         if (rr_data_q.size() == 0)
            stop_run("read beat returned before any read response");
         compare_data("s_axi_rdata", s_axi_rdata, rr_data_q.pop_front());
         compare_resp("s_axi_rresp", s_axi_rresp, rr_resp_q.pop_front());
         compare_flag("s_axi_rlast", s_axi_rlast, i == len);
         @(posedge s_axi_aclk);
      end
   endtask

   // ##############################
   // monitors and responder
   // ##############################
   always @(negedge s_axi_aclk)
   begin
      if (emwr_access)
      begin
         if (wr_addr_q.size() == 0)
            stop_run("write packet appeared with no write beat pending");
         compare_addr("emwr_dstaddr", emwr_dstaddr, wr_addr_q.pop_front());
         compare_data("emwr_data", emwr_data, wr_data_q.pop_front());
         compare_mode("emwr_datamode", emwr_datamode, wr_mode_q.pop_front());
         compare_ctrl("emwr_ctrlmode", emwr_ctrlmode, wr_ctrl_q.pop_front());
      end
      if (s_axi_bvalid && s_axi_bready)
      begin
         compare_resp("s_axi_bresp", s_axi_bresp, RESP_OKAY);
         b_count++;
      end
      if (progfull_seen)
         compare_flag("s_axi_wready", s_axi_wready, 1'b0);  // throttled after prog-full
      progfull_seen = emwr_progfull;
      if (s_axi_aresetn)
         compare_flag("emrr_rd_en", emrr_rd_en, emrr_access);  // pop with each response
   end

   initial
   begin : responder
      data_t d;
      logic t;
      int delay;
      emrr_access = 1'b0;
      emrr_data = '0;
      emrr_timeout = 1'b0;
      forever
      begin
         @(negedge s_axi_aclk);
         if (emrq_access)
         begin
            if (rq_addr_q.size() == 0)
               stop_run("read request appeared with no read beat pending");
            compare_addr("emrq_dstaddr", emrq_dstaddr, rq_addr_q.pop_front());
            compare_mode("emrq_datamode", emrq_datamode, rq_mode);
            compare_ctrl("emrq_ctrlmode", emrq_ctrlmode, rq_ctrl);
            delay = 1 + $unsigned($random(seed)) % 5;
            repeat (delay)
            begin
               @(negedge s_axi_aclk);
               if (emrq_access)
                  stop_run("second read request sent before the first was answered");
            end
            d = $random(seed);
            t = ($random(seed) & 3) == 0;  // timeout now and then
            @(posedge s_axi_aclk);
            emrr_data <= d;
            emrr_timeout <= t;
            emrr_access <= 1'b1;
            case (rq_mode)
               2'b00:   rr_data_q.push_back({4{d[7:0]}});  // byte on every lane
               2'b01:   rr_data_q.push_back({2{d[15:0]}});
               default: rr_data_q.push_back(d);
            endcase
            rr_resp_q.push_back(t ? RESP_SLVERR : RESP_OKAY);
            @(posedge s_axi_aclk);
            emrr_access <= 1'b0;
         end
      end
   end

   // random back-pressure on every channel
   initial
   begin
      emwr_progfull = 1'b0;
      s_axi_bready = 1'b0;
      s_axi_rready = 1'b0;
      forever
      begin
         @(posedge s_axi_aclk);
         emwr_progfull <= ($random(seed) & 3) == 0;
         s_axi_bready <= ($random(seed) & 3) != 0;
         s_axi_rready <= ($random(seed) & 3) != 0;
      end
   end

   initial
   begin
      repeat (MAX_CYCLES) @(posedge s_axi_aclk);
      stop_run("watchdog expired before all transactions finished");
   end

   // ##############################
   // main sequence
   // ##############################
   initial
   begin
      s_axi_aresetn = 1'b0;
      ecfg_tx_ctrlmode = '0;
      s_axi_awaddr = '0;
      s_axi_awburst = '0;
      s_axi_awsize = '0;
      s_axi_awvalid = 1'b0;
      s_axi_wdata = '0;
      s_axi_wstrb = '0;
      s_axi_wlast = 1'b0;
      s_axi_wvalid = 1'b0;
      s_axi_araddr = '0;
      s_axi_arburst = '0;
      s_axi_arsize = '0;
      s_axi_arlen = '0;
      s_axi_arvalid = 1'b0;
      repeat (3) @(posedge s_axi_aclk);
      s_axi_aresetn <= 1'b1;
      for (int n = 0; n < NUM_WR; n++)
         write_burst(n % 5 == 4);  // every fifth burst to own id
      for (int n = 0; n < NUM_RD; n++)
         read_burst();
      repeat (10) @(negedge s_axi_aclk);  // drain
      if (b_count == NUM_WR && wr_addr_q.size() == 0 && rq_addr_q.size() == 0)
      begin
         $display("Test completed successfully");
         $finish;
      end
      else
         stop_run("write packets, responses or read requests missing at the end");
   end

endmodule

// File: write/axi_write_channel.sv
`timescale 1ns/1ps

module axi_write_channel import esaxi_pkg::*;
(
   input  logic       s_axi_aclk,
   input  logic       s_axi_aresetn,
   input  addr_t      s_axi_awaddr,
   input  burst_t     s_axi_awburst,
   input  datamode_t  s_axi_awsize,
   input  logic       s_axi_awvalid,
   output logic       s_axi_awready,
   input  data_t      s_axi_wdata,
   input  logic [3:0] s_axi_wstrb,
   input  logic       s_axi_wlast,
   input  logic       s_axi_wvalid,
   output logic       s_axi_wready,
   output resp_t      s_axi_bresp,
   output logic       s_axi_bvalid,
   input  logic       s_axi_bready,
   input  logic       emwr_progfull,
   input  ctrlmode_t  ecfg_tx_ctrlmode,
   emesh_if.src       pkt
);

   logic      write_active;  // between aw handshake and last beat
   logic      beat;          // w handshake
   logic      last_beat;
   addr_t     aw_addr;       // current beat address
   burst_t    aw_burst;
   datamode_t aw_size;
   logic      beat_q;        // beat captured, waiting for alignment
   data_t     wdata_q;
   logic [3:0] wstrb_q;
   addr_t     waddr_q;
   logic [1:0] lane;         // lowest strobed byte lane

   assign beat      = s_axi_wvalid & s_axi_wready;
   assign last_beat = beat & s_axi_wlast;
   assign s_axi_bresp = RESP_OKAY;  // writes never fail

   // ##############################
   // aw / w / b control
   // ##############################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
      begin
         s_axi_awready <= 1'b0;
         write_active  <= 1'b0;
         s_axi_wready  <= 1'b0;
         s_axi_bvalid  <= 1'b0;
      end
      else
      begin
         // idle and no response pending
         if (!s_axi_awready && !write_active && !s_axi_bvalid)
            s_axi_awready <= 1'b1;
         else if (s_axi_awvalid)
            s_axi_awready <= 1'b0;  // address taken
         if (s_axi_awready && s_axi_awvalid)
            write_active <= 1'b1;
         else if (last_beat)
            write_active <= 1'b0;
         if (last_beat)
            s_axi_wready <= 1'b0;
         else
            s_axi_wready <= write_active & ~emwr_progfull;  // throttle on prog-full
         if (last_beat)
            s_axi_bvalid <= 1'b1;   // also the response wait state
         else if (s_axi_bready)
            s_axi_bvalid <= 1'b0;
      end
   end

   // burst address, stepped one word per beat for incr
   always_ff @(posedge s_axi_aclk)
   begin
      if (s_axi_awready && s_axi_awvalid)
      begin
         aw_addr  <= s_axi_awaddr;
         aw_burst <= s_axi_awburst;
         aw_size  <= s_axi_awsize;
      end
      else if (beat && aw_burst == BURST_INCR)
         aw_addr <= {aw_addr[31:ADDR_LSB] + 1'b1, {ADDR_LSB{1'b0}}};
   end

   // ##############################
   // beat capture and alignment
   // ##############################
   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         beat_q <= 1'b0;
      else
         beat_q <= beat;
      if (beat)
      begin
         wdata_q <= s_axi_wdata;
         wstrb_q <= s_axi_wstrb;
         waddr_q <= aw_addr;  // address before stepping
      end
   end

   always_comb
   begin
      if (wstrb_q[0] || aw_size == SIZE_WORD)
         lane = 2'd0;        // full words stay on lane 0
      else if (wstrb_q[1])
         lane = 2'd1;
      else if (wstrb_q[2])
         lane = 2'd2;
      else
         lane = 2'd3;
   end

   always_ff @(posedge s_axi_aclk)
   begin
      if (!s_axi_aresetn)
         pkt.access <= 1'b0;
      else
         pkt.access <= beat_q;
      pkt.datamode <= aw_size;                   // stable through the burst
      pkt.ctrlmode <= ecfg_tx_ctrlmode;
      pkt.dstaddr  <= {waddr_q[31:ADDR_LSB], lane};
      pkt.data     <= wdata_q >> {lane, 3'b000}; // shift down to lane 0
   end

endmodule
